// ==== src/cart_settings.svh ====
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// mapper segment registers sit on four consecutive io ports
`define CART_MAPPER_PORT_BASE 8'hFC

// boot image location in spi flash
`define CART_FLASH_BASE 24'h100000

// bytes copied into cartridge memory at power-up
`define CART_IMAGE_BYTES 32'd256

// byte address width of cartridge memory
`define CART_MEM_AW 16

// segment number width, four 16 KB segments by default
`define CART_SEG_W 2

// msel_n sequence length in clk108_w cycles
`define CART_DEMUX_PHASES 8

`endif

// ==== src/msx_bus_pkg.sv ====
package msx_bus_pkg;

    typedef logic [15:0] msx_addr_t;   // cpu address
    typedef logic [7:0]  msx_data_t;

    // one captured bus cycle as seen through the pin multiplexer
    typedef struct packed {
        msx_addr_t addr;
        logic      merq_n;
        logic      iorq_n;
        logic      m1_n;
        logic      rd_n;      // filtered
        logic      wr_n;      // filtered
        logic      sltsl_n;   // filtered
    } bus_cycle_t;

endpackage

// ==== src/mem_pkg.sv ====
`include "cart_settings.svh"

package mem_pkg;

    typedef logic [`CART_MEM_AW-1:0] mem_addr_t;   // physical byte address
    typedef logic [`CART_SEG_W-1:0]  seg_t;

    // master side of a wishbone classic cycle
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        mem_addr_t  adr;
        logic [7:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;    // valid with ack on reads
    } wb_rsp_t;

    typedef enum logic [1:0] {
        LDR_IDLE,
        LDR_COMMAND,
        LDR_READ,
        LDR_DONE
    } loader_state_e;

    typedef enum logic [1:0] {
        MAP_IDLE,
        MAP_ACCESS,
        MAP_HOLD
    } mapper_state_e;

endpackage

// ==== src/msx_bus_demux.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module msx_bus_demux (
    input  logic                    clk108_w,
    input  logic                    ram_enabled_w,
    input  msx_bus_pkg::msx_data_t  mp,
    input  logic                    sltsl_n,
    input  logic                    rd_n,
    input  logic                    wr_n,
    output logic [2:0]              msel_n,
    output msx_bus_pkg::bus_cycle_t cycle,
    output logic                    cycle_valid
);

    logic [$clog2(`CART_DEMUX_PHASES)-1:0] phase;
    logic [$clog2(`CART_DEMUX_PHASES)-1:0] phase_nxt;
    msx_bus_pkg::msx_data_t addr_lo;
    msx_bus_pkg::msx_data_t addr_hi;
    logic [2:0] strb_meta;     // rd_n wr_n sltsl_n
    logic [2:0] strb_q;

    assign phase_nxt = phase + 1'b1;

    // msel_n is registered from the next phase so it lines up with phase
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            phase  <= '1;          // idle pair
            msel_n <= 3'b111;
        end else begin
            phase <= phase_nxt;
            case (phase_nxt)
                3'd0, 3'd1: msel_n <= 3'b110;   // a7..a0
                3'd2, 3'd3: msel_n <= 3'b101;   // a15..a8
                3'd4, 3'd5: msel_n <= 3'b011;   // merq iorq .. m1
                default:    msel_n <= 3'b111;
            endcase
        end
    end

    // second phase of each pair, pins have settled
    always_ff @(posedge clk108_w) begin
        if (phase == 3'd1)
            addr_lo <= mp;
        if (phase == 3'd3)
            addr_hi <= mp;
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            strb_meta   <= '1;
            strb_q      <= '1;
            cycle       <= '1;
            cycle_valid <= 1'b0;
        end else begin
            strb_meta   <= {rd_n, wr_n, sltsl_n};
            strb_q      <= strb_meta;
            cycle_valid <= (phase == 3'd5);
            if (phase == 3'd5) begin
                cycle <= '{addr:    {addr_hi, addr_lo},
                           merq_n:  mp[0],
                           iorq_n:  mp[1],
                           m1_n:    mp[7],
                           rd_n:    strb_q[2],
                           wr_n:    strb_q[1],
                           sltsl_n: strb_q[0]};
            end
        end
    end

    // only one slice of the multiplexer may be enabled at a time
    assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        $countones(~msel_n) <= 1)
        else $error("msel_n enables more than one slice: %b", msel_n);

endmodule

// ==== src/flash_loader.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module flash_loader (
    input  logic             clk108_w,
    input  logic             ram_enabled_w,
    output logic             mspi_cs,
    output logic             mspi_sclk,
    output logic             mspi_mosi,
    input  logic             mspi_miso,
    output mem_pkg::wb_req_t wb_req,
    input  mem_pkg::wb_rsp_t wb_rsp,
    output logic             done
);

    mem_pkg::loader_state_e state;
    logic [31:0] tx_sr;        // read command then flash address
    logic [4:0]  bit_cnt;
    logic [6:0]  rx_sr;
    logic [31:0] byte_cnt;
    logic        last_byte;

    assign mspi_mosi = tx_sr[31];
    assign done      = (state == mem_pkg::LDR_DONE);
    assign last_byte = (byte_cnt == `CART_IMAGE_BYTES - 1);

    ////////////////////////////////////////////////////////////////////////////
    // spi mode 0 at half clk108_w, one wishbone write per byte
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            state     <= mem_pkg::LDR_IDLE;
            mspi_cs   <= 1'b1;
            mspi_sclk <= 1'b0;
            tx_sr     <= '0;
            bit_cnt   <= '0;
            rx_sr     <= '0;
            byte_cnt  <= '0;
            wb_req    <= '0;
        end else begin
            case (state)
                mem_pkg::LDR_IDLE: begin
                    mspi_cs <= 1'b0;
                    tx_sr   <= {8'h03, `CART_FLASH_BASE};
                    state   <= mem_pkg::LDR_COMMAND;
                end
                mem_pkg::LDR_COMMAND: begin
                    mspi_sclk <= !mspi_sclk;
                    if (mspi_sclk) begin                // falling edge
                        tx_sr   <= tx_sr << 1;
                        bit_cnt <= bit_cnt + 1'b1;      // wraps to 0 for the data phase
                        if (bit_cnt == 5'd31)
                            state <= mem_pkg::LDR_READ;
                    end
                end
                mem_pkg::LDR_READ: begin
                    if (wb_req.cyc && wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        byte_cnt   <= byte_cnt + 1'b1;
                        if (last_byte) begin
                            mspi_cs <= 1'b1;
                            state   <= mem_pkg::LDR_DONE;
                        end
                    end
                    if (mspi_sclk) begin
                        mspi_sclk <= 1'b0;
                    end else if (!wb_req.cyc) begin     // sclk parks low under back-pressure
                        mspi_sclk <= 1'b1;
                        rx_sr     <= {rx_sr[5:0], mspi_miso};
                        bit_cnt   <= bit_cnt + 1'b1;
                        if (bit_cnt[2:0] == 3'd7) begin
                            wb_req.cyc <= 1'b1;
                            wb_req.stb <= 1'b1;
                            wb_req.we  <= 1'b1;
                            wb_req.adr <= byte_cnt[`CART_MEM_AW-1:0];
                            wb_req.dat <= {rx_sr, mspi_miso};
                        end
                    end
                end
                default: ;                              // image copied
            endcase
        end
    end

    assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        $rose(wb_req.stb) |-> wb_req.cyc)
        else $error("loader raised stb without cyc");

endmodule

// ==== src/memory_mapper.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module memory_mapper (
    input  logic                    clk108_w,
    input  logic                    ram_enabled_w,
    input  msx_bus_pkg::bus_cycle_t cycle,
    input  logic                    cycle_valid,
    input  msx_bus_pkg::msx_data_t  cdin,
    output mem_pkg::wb_req_t        wb_req,
    input  mem_pkg::wb_rsp_t        wb_rsp,
    output msx_bus_pkg::msx_data_t  cdout,
    output logic                    mem_drive,
    output logic                    port_drive
);

    mem_pkg::mapper_state_e state;
    mem_pkg::seg_t seg [4];     // one per 16 KB page
    logic armed;
    logic io_hit;
    logic io_wr;
    logic io_rd;
    logic start_mem;
    logic rd_done;

    assign armed  = (state == mem_pkg::MAP_IDLE) && cycle_valid;
    assign io_hit = !cycle.iorq_n && cycle.m1_n
        && ((cycle.addr[7:0] | 8'h03) == (`CART_MAPPER_PORT_BASE | 8'h03));
    assign io_wr  = armed && io_hit && !cycle.wr_n;
    assign io_rd  = armed && io_hit && !cycle.rd_n;
    assign start_mem = armed && !cycle.merq_n && !cycle.sltsl_n
        && !(cycle.rd_n && cycle.wr_n);
    assign rd_done = (state == mem_pkg::MAP_ACCESS) && wb_rsp.ack && !wb_req.we;

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            state      <= mem_pkg::MAP_IDLE;
            seg[0]     <= mem_pkg::seg_t'(3);
            seg[1]     <= mem_pkg::seg_t'(2);
            seg[2]     <= mem_pkg::seg_t'(1);
            seg[3]     <= mem_pkg::seg_t'(0);
            wb_req     <= '0;
            mem_drive  <= 1'b0;
            port_drive <= 1'b0;
        end else begin
            case (state)
                mem_pkg::MAP_IDLE: begin
                    if (io_wr) begin
                        seg[cycle.addr[1:0]] <= cdin[`CART_SEG_W-1:0];
                        state <= mem_pkg::MAP_HOLD;
                    end else if (io_rd) begin
                        port_drive <= 1'b1;
                        state      <= mem_pkg::MAP_HOLD;
                    end else if (start_mem) begin
                        wb_req <= '{cyc: 1'b1,
                                    stb: 1'b1,
                                    we:  !cycle.wr_n,
                                    adr: {seg[cycle.addr[15:14]], cycle.addr[13:0]},
                                    dat: cdin};
                        state  <= mem_pkg::MAP_ACCESS;
                    end
                end
                mem_pkg::MAP_ACCESS: if (wb_rsp.ack) begin
                    wb_req.cyc <= 1'b0;
                    wb_req.stb <= 1'b0;
                    mem_drive  <= !wb_req.we;
                    state      <= mem_pkg::MAP_HOLD;
                end
                default: if (cycle_valid && cycle.rd_n && cycle.wr_n) begin   // re-arm
                    mem_drive  <= 1'b0;
                    port_drive <= 1'b0;
                    state      <= mem_pkg::MAP_IDLE;
                end
            endcase
        end
    end

    // read byte for the cpu, port reads pad the segment with ones
    always_ff @(posedge clk108_w) begin
        if (io_rd)
            cdout <= {{(8 - `CART_SEG_W){1'b1}}, seg[cycle.addr[1:0]]};
        else if (rd_done)
            cdout <= wb_rsp.dat;
    end

    assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        start_mem |-> !wb_req.cyc)
        else $error("mapper started an access with cyc already high");

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic             clk108_w,
    input  logic             ram_enabled_w,
    input  mem_pkg::wb_req_t ldr_req,
    output mem_pkg::wb_rsp_t ldr_rsp,
    input  mem_pkg::wb_req_t map_req,
    output mem_pkg::wb_rsp_t map_rsp,
    output mem_pkg::wb_req_t ram_req,
    input  mem_pkg::wb_rsp_t ram_rsp
);

    logic gnt_map;     // mapper owns the memory

    // grant moves only between cycles, loader first
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            gnt_map <= 1'b0;
        end else if (!ram_req.cyc) begin
            if (ldr_req.cyc)
                gnt_map <= 1'b0;
            else if (map_req.cyc)
                gnt_map <= 1'b1;
        end
    end

    assign ram_req = gnt_map ? map_req : ldr_req;
    assign ldr_rsp = '{ack: ram_rsp.ack & ~gnt_map, dat: ram_rsp.dat};
    assign map_rsp = '{ack: ram_rsp.ack & gnt_map, dat: ram_rsp.dat};

    // an ack answers the master that still holds the grant and its cycle
    assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        ram_rsp.ack |-> $stable(gnt_map) && (map_rsp.ack ? map_req.cyc : ldr_req.cyc))
        else $error("ack misrouted, gnt_map %b", gnt_map);

endmodule

// ==== src/cart_ram.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_ram #(
    parameter int DEPTH_BITS = `CART_MEM_AW
) (
    input  logic             clk108_w,
    input  logic             ram_enabled_w,
    input  mem_pkg::wb_req_t wb_req,
    output mem_pkg::wb_rsp_t wb_rsp
);

    logic [7:0]            mem [2**DEPTH_BITS];
    logic [DEPTH_BITS-1:0] idx;
    logic                  sel;
    logic                  ack_q;
    logic [7:0]            rd_q;

    assign idx    = wb_req.adr[DEPTH_BITS-1:0];
    assign sel    = wb_req.cyc && wb_req.stb && !ack_q;    // first cycle of the request
    assign wb_rsp = '{ack: ack_q, dat: rd_q};

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w)
            ack_q <= 1'b0;
        else
            ack_q <= sel;
    end

    always_ff @(posedge clk108_w) begin
        if (sel && wb_req.we)
            mem[idx] <= wb_req.dat;
        rd_q <= mem[idx];
    end

endmodule

// ==== src/cart_bus_top.sv ====
`timescale 1ns/1ps

module cart_bus_top (
    input  logic                   clk108_w,
    input  logic                   ram_enabled_w,
    input  msx_bus_pkg::msx_data_t mp,
    input  logic                   sltsl_n,
    input  logic                   rd_n,
    input  logic                   wr_n,
    inout  wire [7:0]              cd,
    output logic [2:0]             msel_n,
    output logic                   datadir,
    output logic                   busdir_n,
    output logic                   wait_n,
    output logic                   mspi_cs,
    output logic                   mspi_sclk,
    output logic                   mspi_mosi,
    input  logic                   mspi_miso,
    output logic                   int_n
);

    msx_bus_pkg::bus_cycle_t cycle;
    logic                    cycle_valid;
    mem_pkg::wb_req_t        ldr_req;
    mem_pkg::wb_rsp_t        ldr_rsp;
    mem_pkg::wb_req_t        map_req;
    mem_pkg::wb_rsp_t        map_rsp;
    mem_pkg::wb_req_t        ram_req;
    mem_pkg::wb_rsp_t        ram_rsp;
    msx_bus_pkg::msx_data_t  map_cdout;
    logic                    loader_done;
    logic                    mem_drive;
    logic                    port_drive;

    ////////////////////////////////////////////////////////////////////////////
    // msx side
    ////////////////////////////////////////////////////////////////////////////
    msx_bus_demux u_demux (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .sltsl_n       (sltsl_n),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .msel_n        (msel_n),
        .cycle         (cycle),
        .cycle_valid   (cycle_valid)
    );

    memory_mapper u_mapper (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .cycle         (cycle),
        .cycle_valid   (cycle_valid),
        .cdin          (cd),
        .wb_req        (map_req),
        .wb_rsp        (map_rsp),
        .cdout         (map_cdout),
        .mem_drive     (mem_drive),
        .port_drive    (port_drive)
    );

    assign datadir  = !((mem_drive || port_drive) && !rd_n);  // raw rd_n frees the bus at once
    assign cd       = datadir ? 8'bzzzzzzzz : map_cdout;
    assign busdir_n = !port_drive;
    assign int_n    = 1'b1;     // no interrupt source

    // cpu waits until the boot image is in memory
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w)
            wait_n <= 1'b0;
        else
            wait_n <= loader_done;
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////////////////////
    flash_loader u_loader (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mspi_cs       (mspi_cs),
        .mspi_sclk     (mspi_sclk),
        .mspi_mosi     (mspi_mosi),
        .mspi_miso     (mspi_miso),
        .wb_req        (ldr_req),
        .wb_rsp        (ldr_rsp),
        .done          (loader_done)
    );

    mem_arbiter u_arbiter (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .ldr_req       (ldr_req),
        .ldr_rsp       (ldr_rsp),
        .map_req       (map_req),
        .map_rsp       (map_rsp),
        .ram_req       (ram_req),
        .ram_rsp       (ram_rsp)
    );

    cart_ram u_ram (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .wb_req        (ram_req),
        .wb_rsp        (ram_rsp)
    );

endmodule

// ==== bench/spi_flash_model.sv ====
`timescale 1ns/1ps

module spi_flash_model (
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);

    logic [31:0] rx_sr;        // command byte then 24-bit address
    logic [5:0]  rx_cnt;
    logic [15:0] tx_cnt;       // data bits sent so far
    logic [23:0] rd_addr;
    logic [7:0]  rd_byte;
    logic        tx_bit;

    assign rd_addr = rx_sr[23:0] + 24'(tx_cnt[15:3]);
    assign rd_byte = (rx_sr[31:24] == 8'h03) ? (rd_addr[7:0] ^ 8'h5A) : 8'hFF;
    assign miso    = cs ? 1'b0 : tx_bit;

    // mode 0, mosi taken on the rising edge
    always @(posedge sclk or posedge cs) begin
        if (cs) begin
            rx_cnt <= '0;
        end else if (rx_cnt < 6'd32) begin
            rx_sr  <= {rx_sr[30:0], mosi};
            rx_cnt <= rx_cnt + 1'b1;
        end
    end

    // data changes on the falling edge, msb first
    always @(negedge sclk or posedge cs) begin
        if (cs) begin
            tx_cnt <= '0;
            tx_bit <= 1'b0;
        end else if (rx_cnt == 6'd32) begin
            tx_bit <= rd_byte[3'd7 - tx_cnt[2:0]];
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

endmodule

// ==== bench/tb_cart_bus.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module tb_cart_bus;

    localparam int LOAD_TIMEOUT = 20000;
    localparam int MODE_NONE    = 0;
    localparam int MODE_READ    = 1;     // cd checked
    localparam int MODE_PORT    = 2;     // cd and busdir_n checked
    localparam int MODE_IDLE    = 3;     // bus must stay released

    logic        clk108_w;
    logic        ram_enabled_w;
    logic [7:0]  mp;
    logic        sltsl_n;
    logic        rd_n;
    logic        wr_n;
    tri1  [7:0]  cd;            // pulled up while nobody drives
    logic [2:0]  msel_n;
    logic        datadir;
    logic        busdir_n;
    logic        wait_n;
    logic        int_n;
    logic        mspi_cs;
    logic        mspi_sclk;
    logic        mspi_mosi;
    logic        mspi_miso;
    logic [15:0] addr_q;        // host side of the pin multiplexer
    logic [7:0]  ctrl_q;        // m1_n bit 7, iorq_n bit 1, merq_n bit 0
    logic [7:0]  cd_drv;
    logic        cd_oe;
    logic        chk_reset;
    logic        chk_rd;
    logic        chk_port;
    logic        chk_idle;
    logic [7:0]  exp_cd;
    int          errors;
    int          test_errors;
    int          tests_failed;
    logic [13:0] wr_off [4];
    logic [7:0]  wr_data [4];

    cart_bus_top i_dut (
        .clk108_w (clk108_w), .ram_enabled_w (ram_enabled_w), .mp (mp),
        .sltsl_n (sltsl_n), .rd_n (rd_n), .wr_n (wr_n), .cd (cd), .msel_n (msel_n),
        .datadir (datadir), .busdir_n (busdir_n), .wait_n (wait_n),
        .mspi_cs (mspi_cs), .mspi_sclk (mspi_sclk), .mspi_mosi (mspi_mosi),
        .mspi_miso (mspi_miso), .int_n (int_n)
    );

    spi_flash_model u_flash (
        .cs (mspi_cs), .sclk (mspi_sclk), .mosi (mspi_mosi), .miso (mspi_miso)
    );

    assign cd = cd_oe ? cd_drv : 8'bzzzzzzzz;
    assign mp = (msel_n == 3'b110) ? addr_q[7:0]
              : (msel_n == 3'b101) ? addr_q[15:8]
              : (msel_n == 3'b011) ? ctrl_q : 8'hFF;

    initial begin
        clk108_w = 1'b0;
        forever #10 clk108_w = ~clk108_w;
    end

    function automatic void report_mismatch(input string name, input logic [7:0] got,
                                            input logic [7:0] exp);
        errors++;
        $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endfunction

    function automatic logic [7:0] image_byte(input int k);
        logic [23:0] a;
        a = `CART_FLASH_BASE + 24'(k);
        return a[7:0] ^ 8'h5A;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    assert property (@(posedge clk108_w) chk_reset |-> msel_n == 3'b111)
        else report_mismatch("msel_n", 8'(msel_n), 8'h07);
    assert property (@(posedge clk108_w) chk_reset |-> datadir)
        else report_mismatch("datadir", 8'(datadir), 8'h01);
    assert property (@(posedge clk108_w) chk_reset |-> !wait_n)
        else report_mismatch("wait_n", 8'(wait_n), 8'h00);
    assert property (@(posedge clk108_w) chk_reset |-> mspi_cs)
        else report_mismatch("mspi_cs", 8'(mspi_cs), 8'h01);
    assert property (@(posedge clk108_w) $rose(wait_n) |-> mspi_cs)   // loader released flash
        else report_mismatch("mspi_cs", 8'(mspi_cs), 8'h01);
    assert property (@(posedge clk108_w) chk_rd |-> cd == exp_cd)
        else report_mismatch("cd", cd, exp_cd);
    assert property (@(posedge clk108_w) chk_rd |-> !datadir)
        else report_mismatch("datadir", 8'(datadir), 8'h00);
    assert property (@(posedge clk108_w) chk_port |-> !busdir_n)
        else report_mismatch("busdir_n", 8'(busdir_n), 8'h00);
    assert property (@(posedge clk108_w) chk_idle |-> datadir && busdir_n)
        else report_mismatch("datadir", 8'(datadir), 8'h01);
    assert property (@(posedge clk108_w) chk_idle |-> cd == 8'hFF)
        else report_mismatch("cd", cd, 8'hFF);
    assert property (@(posedge clk108_w) int_n)    // no interrupt source on this cartridge
        else report_mismatch("int_n", 8'(int_n), 8'h01);

    // one cpu bus cycle, strobes held 40 clocks, outputs checked at clock 36
    task automatic cpu_cycle(input bit io, input bit wr, input bit slot,
                             input logic [15:0] a, input logic [7:0] dat, input int mode);
        addr_q = a;
        repeat (10) @(negedge clk108_w);
        ctrl_q  = io ? 8'hFD : 8'hFE;
        sltsl_n = !slot;
        rd_n    = wr;
        wr_n    = !wr;
        cd_drv  = dat;
        cd_oe   = wr;
        exp_cd  = dat;
        for (int i = 1; i <= 40; i++) begin
            @(negedge clk108_w);
            chk_rd   = (i == 35) && (mode == MODE_READ || mode == MODE_PORT);
            chk_port = (i == 35) && (mode == MODE_PORT);
            chk_idle = (i == 35) && (mode == MODE_IDLE);
        end
        rd_n    = 1'b1;
        wr_n    = 1'b1;
        sltsl_n = 1'b1;
        ctrl_q  = 8'hFF;
        cd_oe   = 1'b0;
        repeat (20) @(negedge clk108_w);     // lets the mapper re-arm
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] rnd;
        int          off;
        void'($urandom(32'hc324_d8e9));
        ram_enabled_w = 1'b0;
        sltsl_n       = 1'b1;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        addr_q        = '0;
        ctrl_q        = 8'hFF;
        cd_drv        = '0;
        cd_oe         = 1'b0;
        exp_cd        = '0;
        chk_reset     = 1'b0;
        chk_rd        = 1'b0;
        chk_port      = 1'b0;
        chk_idle      = 1'b0;
        errors        = 0;
        test_errors   = 0;
        tests_failed  = 0;

        repeat (15) @(negedge clk108_w);
        chk_reset = 1'b1;
        @(negedge clk108_w);
        chk_reset     = 1'b0;
        ram_enabled_w = 1'b1;

        for (int i = 0; i < LOAD_TIMEOUT && !wait_n; i++)
            @(negedge clk108_w);
        if (!wait_n) begin
            $display("timeout: wait_n did not rise, boot image copy never finished");
            $display("Errors found");
            $finish;
        end
        repeat (2) @(negedge clk108_w);
        end_test("reset and boot load");

        for (int p = 0; p < 4; p++)
            cpu_cycle(1, 0, 0, {8'h00, `CART_MAPPER_PORT_BASE + 8'(p)}, 8'hFC | 8'(3 - p),
                      MODE_PORT);
        end_test("mapper reset values");

        cpu_cycle(1, 1, 0, {8'h00, `CART_MAPPER_PORT_BASE}, 8'h00, MODE_NONE);
        for (int i = 0; i < 4; i++) begin
            off = int'($urandom % `CART_IMAGE_BYTES);
            cpu_cycle(0, 0, 1, 16'(off), image_byte(off), MODE_READ);
        end
        end_test("boot image in page 0");

        cpu_cycle(1, 1, 0, {8'h00, `CART_MAPPER_PORT_BASE + 8'd2}, 8'h01, MODE_NONE);
        for (int i = 0; i < 4; i++) begin
            rnd        = $urandom;
            wr_off[i]  = {rnd[10:0], 3'(i)};    // distinct offsets
            wr_data[i] = rnd[31:24];
            cpu_cycle(0, 1, 1, {2'b10, wr_off[i]}, wr_data[i], MODE_NONE);
        end
        cpu_cycle(1, 1, 0, {8'h00, `CART_MAPPER_PORT_BASE + 8'd1}, 8'h01, MODE_NONE);
        for (int i = 0; i < 4; i++)
            cpu_cycle(0, 0, 1, {2'b01, wr_off[i]}, wr_data[i], MODE_READ);
        cpu_cycle(1, 0, 0, {8'h00, `CART_MAPPER_PORT_BASE + 8'd1}, 8'hFD, MODE_PORT);
        cpu_cycle(1, 0, 0, {8'h00, `CART_MAPPER_PORT_BASE + 8'd2}, 8'hFD, MODE_PORT);
        end_test("segment shared by two pages");

        cpu_cycle(0, 0, 0, 16'h0010, 8'hFF, MODE_IDLE);
        cpu_cycle(1, 0, 0, 16'h0010, 8'hFF, MODE_IDLE);
        cpu_cycle(1, 0, 0, 16'h00FB, 8'hFF, MODE_IDLE);
        end_test("bus left released");

        $display("tests run: 5, tests failed: %0d, errors: %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== cart_bus_top.f ====
+incdir+src
src/msx_bus_pkg.sv
src/mem_pkg.sv
src/msx_bus_demux.sv
src/flash_loader.sv
src/memory_mapper.sv
src/mem_arbiter.sv
src/cart_ram.sv
src/cart_bus_top.sv
bench/spi_flash_model.sv
bench/tb_cart_bus.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cart_bus
RTL_TOP   ?= cart_bus_top
FILELIST  ?= cart_bus_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) src/cart_settings.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
